//--- spi_ctrl.f
hdl/spi_pkg.sv
hdl/spi_sclk_gen.sv
hdl/spi_shifter.sv
hdl/spi_cmd_fsm.sv
hdl/spi_ctrl.sv
bench/spi_slave_model.sv
bench/spi_ctrl_tb.sv

//--- Bender.yml
package:
  name: spi_ctrl

sources:
  - hdl/spi_pkg.sv
  - hdl/spi_sclk_gen.sv
  - hdl/spi_shifter.sv
  - hdl/spi_cmd_fsm.sv
  - hdl/spi_ctrl.sv
  - target: simulation
    files:
      - bench/spi_slave_model.sv
      - bench/spi_ctrl_tb.sv

//--- bench/spi_ctrl_tb.sv
module spi_ctrl_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import spi_pkg::*;

  localparam int HALF_PERIOD  = 5;
  localparam int READ_GAP     = 100;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int N_CMDS       = 54;
  localparam int CMD_CYCLES   = 2 * CMD_WIDTH * HALF_PERIOD * 2 + READ_GAP + 50;

  logic    clk = 1'b0;
  logic    rst_n;
  cmd_t    cmd_in;
  logic    cmd_vld;
  logic    cmd_rdy;
  logic    sclk;
  logic    cs;
  logic    mosi;
  logic    miso;
  logic    read_vld;
  read_t   read_data;
  int      frame_cnt;
  cmd_t    frame_bits;
  int      frame_len;

  read_t   ref_mem [0:7];
  cmd_t    exp_bits_q [$];
  int      exp_len_q [$];
  string   exp_name_q [$];
  read_t   exp_data_q [$];
  int      exp_order_q [$];
  string   rd_name_q [$];
  int      frames_predicted = 0;
  int      frames_seen = 0;
  int      errors = 0;
  logic    after_hdr = 1'b0;
  realtime cs_rise_t = 0.0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  spi_ctrl #(
    .HALF_PERIOD (HALF_PERIOD),
    .READ_GAP    (READ_GAP)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model i_slave (
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .miso       (miso),
    .frame_cnt  (frame_cnt),
    .frame_bits (frame_bits),
    .frame_len  (frame_len)
  );

  // ================================================
  // reference model
  // ================================================
  function automatic void expect_frame(input cmd_t bits, input int len, input string name);
    exp_bits_q.push_back(bits);
    exp_len_q.push_back(len);
    exp_name_q.push_back(name);
    frames_predicted++;
  endfunction

  // mosi content of the read data frame is left open.
  function automatic void predict(input cmd_t c, input string name);
    if (c[CMD_WIDTH-1])
      expect_frame(c, CMD_WIDTH, name);
    else
    begin
      expect_frame(cmd_t'(c[CMD_WIDTH-1 -: ADDR_WIDTH]), ADDR_WIDTH, name);
      expect_frame('x, READ_WIDTH, name);
      exp_data_q.push_back(ref_mem[c[CMD_WIDTH-2 -: 3]]);
      exp_order_q.push_back(frames_predicted);
      rd_name_q.push_back(name);
    end
  endfunction

  task automatic check_idle_pins();
    logic [4:0] got;
    got = {cs, cmd_rdy, sclk, mosi, read_vld};
    if (got !== 5'b11000)
    begin
      $display("ERROR reset_state: {cs,cmd_rdy,sclk,mosi,read_vld} expected 11000 actual %b",
               got);
      errors++;
    end
  endtask

  task automatic send_cmd(input cmd_t c, input string name);
    @(posedge clk);
    #1;
    while (cmd_rdy !== 1'b1)
    begin
      @(posedge clk);
      #1;
    end
    predict(c, name);
    cmd_in  = c;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  // one cmd_vld cycle while the master is busy.
  task automatic poke_busy();
    @(posedge clk);
    #1;
    if (cmd_rdy !== 1'b0)
    begin
      $display("cmd_rdy was high in the middle of a transaction");
      errors++;
    end
    cmd_in  = 12'hABC;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  // ================================================
  // checkers
  // ================================================
  always @(frame_cnt)
  begin : frame_check
    cmd_t  eb;
    int    el;
    string nm;
    if (frame_cnt != 0)
    begin
      frames_seen++;
      after_hdr = (frame_len == ADDR_WIDTH);
      if (exp_len_q.size() == 0)
      begin
        $display("unexpected %0d-bit frame with no command pending", frame_len);
        errors++;
      end
      else
      begin
        eb = exp_bits_q.pop_front();
        el = exp_len_q.pop_front();
        nm = exp_name_q.pop_front();
        if (frame_len != el)
        begin
          $display("ERROR %s: frame length expected %0d actual %0d", nm, el, frame_len);
          errors++;
        end
        if (!$isunknown(eb) && frame_bits !== eb)
        begin
          $display("ERROR %s: frame bits expected 0x%03h actual 0x%03h", nm, eb, frame_bits);
          errors++;
        end
      end
    end
  end

  always @(posedge cs)
    cs_rise_t = $realtime;

  always @(negedge cs)
  begin : gap_check
    int gap;
    if (after_hdr)
    begin
      gap = int'(($realtime - cs_rise_t) / CLK_PERIOD);
      if (gap != READ_GAP)
      begin
        $display("ERROR read_gap: cs high cycles expected %0d actual %0d", READ_GAP, gap);
        errors++;
      end
    end
  end

  always @(negedge clk)
  begin : read_check
    read_t ed;
    int    order;
    string nm;
    if (rst_n === 1'b1 && read_vld === 1'b1)
    begin
      if (exp_data_q.size() == 0)
      begin
        $display("read_vld pulsed with no read pending");
        errors++;
      end
      else
      begin
        ed    = exp_data_q.pop_front();
        order = exp_order_q.pop_front();
        nm    = rd_name_q.pop_front();
        if (frames_seen < order)
        begin
          $display("read_vld pulsed before its data frame ended");
          errors++;
        end
        if (read_data !== ed)
        begin
          $display("ERROR %s: read_data expected 0x%02h actual 0x%02h", nm, ed, read_data);
          errors++;
        end
      end
    end
  end

  // ================================================
  // stimulus
  // ================================================
  initial
  begin : main
    int unsigned seed;
    int unsigned junk;
    int          drain;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    seed    = 90848;
    junk    = $urandom(seed);
    for (int a = 0; a < 8; a++)
    begin
      ref_mem[a] = read_t'($urandom);
      i_slave.load_word(a, ref_mem[a]);
    end
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_idle_pins();
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_idle_pins();

    send_cmd(12'h8A5, "write_frame");
    send_cmd(12'hFFF, "write_frame");
    send_cmd(12'h800, "write_frame");
    send_cmd(12'hC3C, "write_frame");
    // every address once.
    for (int a = 0; a < 8; a++)
      send_cmd(cmd_t'(a * 256 + a * 29 + 7), "read_frame");

    send_cmd(12'hE71, "busy_ignore");
    @(negedge cs);
    poke_busy();
    send_cmd(12'h3C5, "busy_ignore");
    @(negedge cs);
    poke_busy();
    @(posedge cs);
    poke_busy();
    @(negedge cs);
    poke_busy();

    for (int i = 0; i < 40; i++)
      send_cmd(cmd_t'($urandom), "random_mix");

    drain = 0;
    while ((exp_len_q.size() != 0 || exp_data_q.size() != 0 || cmd_rdy !== 1'b1)
           && drain < CMD_CYCLES)
    begin
      @(negedge clk);
      drain++;
    end
    if (drain >= CMD_CYCLES)
    begin
      $display("expected frames or read data never arrived");
      errors++;
    end
    repeat (20) @(negedge clk);

    $display("%0d frames checked, %0d errors", frames_seen, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin : watchdog
    #((RESET_CYCLES + N_CMDS * CMD_CYCLES) * CLK_PERIOD);
    $display("timeout, the run did not finish in %0d cycles",
             RESET_CYCLES + N_CMDS * CMD_CYCLES);
    $display("%0d frames checked, %0d errors", frames_seen, errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- bench/spi_slave_model.sv
module spi_slave_model (
  input  logic        sclk,
  input  logic        cs,
  input  logic        mosi,
  output logic        miso,
  output int          frame_cnt,
  output logic [11:0] frame_bits,
  output int          frame_len
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]  mem [0:7];
  logic [11:0] bits;
  logic [7:0]  tx_word;
  int          len;
  int          prev_len;
  logic [2:0]  prev_addr;

  task automatic load_word(input int addr, input logic [7:0] data);
    mem[addr] = data;
  endtask

  initial
  begin
    miso       = 1'b0;
    frame_cnt  = 0;
    frame_bits = '0;
    frame_len  = 0;
    prev_len   = 0;
    prev_addr  = '0;
    forever
    begin
      @(negedge cs);
      bits = '0;
      len  = 0;
      // data frame right after a 4-bit header.
      tx_word = (prev_len == 4) ? mem[prev_addr] : 8'h00;
      miso    = tx_word[7];
      while (cs === 1'b0)
      begin
        @(posedge sclk or negedge sclk or posedge cs);
        if (cs === 1'b0 && sclk === 1'b1)
        begin
          bits = {bits[10:0], mosi};
          len++;
        end
        else if (cs === 1'b0)
        begin
          tx_word = {tx_word[6:0], 1'b0};
          miso    = tx_word[7];
        end
      end
      prev_len   = len;
      prev_addr  = bits[2:0];
      miso       = 1'b0;
      frame_bits = bits;
      frame_len  = len;
      frame_cnt++;
    end
  end

endmodule

//--- hdl/spi_ctrl.sv
module spi_ctrl #(
  parameter int HALF_PERIOD = 5,
  parameter int READ_GAP    = 100
) (
  input  logic           clk,
  input  logic           rst_n,
  input  spi_pkg::cmd_t  cmd_in,
  input  logic           cmd_vld,
  output logic           cmd_rdy,
  output logic           sclk,
  output logic           cs,
  output logic           mosi,
  input  logic           miso,
  output logic           read_vld,
  output spi_pkg::read_t read_data
);

  import spi_pkg::*;

  logic run;
  logic rise;
  logic fall;
  logic load;
  cmd_t load_data;
  logic shift;
  logic capture;

  spi_sclk_gen #(
    .HALF_PERIOD (HALF_PERIOD)
  ) i_sclk_gen (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .sclk  (sclk),
    .rise  (rise),
    .fall  (fall)
  );

  spi_shifter i_shifter (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .load_data (load_data),
    .shift     (shift),
    .capture   (capture),
    .miso      (miso),
    .mosi      (mosi),
    .rx_data   (read_data)
  );

  spi_cmd_fsm #(
    .READ_GAP (READ_GAP)
  ) i_cmd_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .cs        (cs),
    .run       (run),
    .rise      (rise),
    .fall      (fall),
    .load      (load),
    .load_data (load_data),
    .shift     (shift),
    .capture   (capture),
    .read_vld  (read_vld)
  );

endmodule

//--- hdl/spi_cmd_fsm.sv
module spi_cmd_fsm #(
  parameter int READ_GAP = 100
) (
  input  logic          clk,
  input  logic          rst_n,
  input  spi_pkg::cmd_t cmd_in,
  input  logic          cmd_vld,
  output logic          cmd_rdy,
  output logic          cs,
  output logic          run,
  input  logic          rise,
  input  logic          fall,
  output logic          load,
  output spi_pkg::cmd_t load_data,
  output logic          shift,
  output logic          capture,
  output logic          read_vld
);

  import spi_pkg::*;

  localparam int BIT_W = $clog2(CMD_WIDTH + 1);
  localparam int GAP_W = $clog2(READ_GAP + 1);

  spi_state_e       state;
  spi_state_e       state_nxt;
  cmd_t             cmd_q;
  hdr_t             hdr;
  logic [BIT_W-1:0] bit_cnt;
  logic [BIT_W-1:0] frame_len;
  logic [GAP_W-1:0] gap_cnt;
  logic             frame_done;
  logic             gap_done;
  logic             is_write;

  assign is_write = cmd_q[CMD_WIDTH-1];
  assign hdr      = cmd_q[CMD_WIDTH-1 -: ADDR_WIDTH];

  // ================================================
  // frame bookkeeping
  // ================================================
  always_comb
  begin
    case (state)
      R_HDR:   frame_len = BIT_W'(ADDR_WIDTH);
      R_DATA:  frame_len = BIT_W'(READ_WIDTH);
      default: frame_len = BIT_W'(CMD_WIDTH);
    endcase
  end

  // a frame closes on the fall after its last rise.
  assign frame_done = fall && (bit_cnt == frame_len);
  assign gap_done   = (gap_cnt == GAP_W'(READ_GAP - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (!run)
      bit_cnt <= '0;
    else if (rise)
      bit_cnt <= bit_cnt + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      gap_cnt <= '0;
    else if (state == R_GAP)
      gap_cnt <= gap_cnt + 1'b1;
    else
      gap_cnt <= '0;
  end

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      cmd_q <= cmd_in;
  end

  // ================================================
  // state machine
  // ================================================
  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:   if (cmd_vld) state_nxt = LOAD;
      LOAD:   state_nxt = is_write ? W_DATA : R_HDR;
      W_DATA: if (frame_done) state_nxt = W_END;
      W_END:  state_nxt = IDLE;
      R_HDR:  if (frame_done) state_nxt = R_GAP;
      R_GAP:  if (gap_done) state_nxt = R_DATA;
      R_DATA: if (frame_done) state_nxt = R_END;
      R_END:  state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_vld <= 1'b0;
    else
      read_vld <= (state == R_END);
  end

  assign run     = state inside {W_DATA, R_HDR, R_DATA};
  assign cs      = !run;
  assign cmd_rdy = (state == IDLE);
  assign load    = (state == LOAD);
  assign shift   = fall && run;
  assign capture = rise && (state == R_DATA);

  // header sits at the top so it leaves first.
  assign load_data = is_write ? cmd_q : {hdr, {(CMD_WIDTH - ADDR_WIDTH){1'b0}}};

  // ================================================
  // checks
  // ================================================
  a_idle_cs: assert property (@(posedge clk) disable iff (!rst_n)
    (state == IDLE) |=> cs)
    else $error("cs dropped straight out of IDLE");

  a_vld_src: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> cmd_rdy && $past(state, 2) == R_DATA)
    else $error("read_vld outside the end of a read");

  a_rdy_cs: assert property (@(posedge clk) disable iff (!rst_n)
    !cs |-> !cmd_rdy && !$past(cmd_rdy))
    else $error("cmd_rdy high during a frame or just before it");

endmodule

//--- hdl/spi_shifter.sv
module spi_shifter (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           load,
  input  spi_pkg::cmd_t  load_data,
  input  logic           shift,
  input  logic           capture,
  input  logic           miso,
  output logic           mosi,
  output spi_pkg::read_t rx_data
);

  import spi_pkg::*;

  cmd_t tx_q;

  // ================================================
  // transmit side
  // ================================================

  // msb first, zeros fill in from the bottom.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tx_q <= '0;
    else if (load)
      tx_q <= load_data;
    else if (shift)
      tx_q <= {tx_q[CMD_WIDTH-2:0], 1'b0};
  end

  assign mosi = tx_q[CMD_WIDTH-1];

  // ================================================
  // receive side
  // ================================================

  // sampled on the sclk rise.
  always_ff @(posedge clk)
  begin
    if (capture)
      rx_data <= {rx_data[READ_WIDTH-2:0], miso};
  end

endmodule

//--- hdl/spi_sclk_gen.sv
module spi_sclk_gen #(
  parameter int HALF_PERIOD = 5
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic sclk,
  output logic rise,
  output logic fall
);

  localparam int CNT_W = $clog2(HALF_PERIOD + 1);

  logic [CNT_W-1:0] half_cnt;
  logic             toggle;

  // last clk of a half period.
  assign toggle = run && (half_cnt == CNT_W'(HALF_PERIOD - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      half_cnt <= '0;
    else if (!run || toggle)
      half_cnt <= '0;
    else
      half_cnt <= half_cnt + 1'b1;
  end

  // sclk parks low between frames.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk <= 1'b0;
      rise <= 1'b0;
      fall <= 1'b0;
    end
    else
    begin
      rise <= toggle && !sclk;
      fall <= toggle && sclk;
      if (!run)
        sclk <= 1'b0;
      else if (toggle)
        sclk <= ~sclk;
    end
  end

  a_edge_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(rise && fall) && ((rise || fall) == (sclk != $past(sclk))))
    else $error("rise or fall out of step with sclk");

endmodule

//--- hdl/spi_pkg.sv
package spi_pkg;

  // ================================================
  // frame widths
  // ================================================
  localparam int CMD_WIDTH  = 12;
  localparam int ADDR_WIDTH = 4;
  localparam int READ_WIDTH = 8;

  typedef logic [CMD_WIDTH-1:0]  cmd_t;
  typedef logic [ADDR_WIDTH-1:0] hdr_t;
  typedef logic [READ_WIDTH-1:0] read_t;

  // ================================================
  // master states
  // ================================================
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    W_DATA,
    W_END,
    R_HDR,
    R_GAP,
    R_DATA,
    R_END
  } spi_state_e;

endpackage
